//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_ddr_mem
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests
FAIL_MSG  = FAIL: see errors above

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/ddr_cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_cmd_sequencer #(
  parameter int INIT_CYCLES = 100,
  parameter int T_RP        = 3,
  parameter int T_RCD       = 3,
  parameter int CL          = 6
) (
  input  wire logic                              mclk,
  input  wire logic                              arst_n,
  output logic                                   configured_o,
  input  wire mem_cmd_pkg::mem_req_t             req_i,
  input  wire logic                              req_empty_i,
  output logic                                   req_pop_o,
  input  wire logic                              rd_full_i,
  output logic                                   rd_push_o,
  output logic [mem_cfg_pkg::DATA_BITS-1:0]      rd_word_o,
  output mem_cmd_pkg::dfi_cmd_t                  dfi_cmd_o,
  output logic [mem_cfg_pkg::DATA_BITS-1:0]      dfi_wdata_o,
  input  wire logic                              dfi_rvld_i,
  input  wire logic [mem_cfg_pkg::DATA_BITS-1:0] dfi_rdata_i
);

  import mem_cfg_pkg::*;
  import mem_cmd_pkg::*;

  localparam int CNT_W = 16;
  localparam int BANKS = 1 << BANK_BITS;

  typedef enum logic [3:0] {
    ST_RESET, ST_POWERUP, ST_PREA_WAIT, ST_IDLE, ST_OPEN,
    ST_PRE_WAIT, ST_ACT_WAIT, ST_READ
  } seq_state_e;

  seq_state_e           state_q;
  logic [CNT_W-1:0]     cnt_q;    // Shared by init, tRP, tRCD and CL
  logic                 cke_q;
  logic                 configured_q;
  logic [BANKS-1:0]     open_q;
  logic [ROW_BITS-1:0]  row_q [BANKS];
  mem_req_t             req_q;

  logic [BANK_BITS-1:0] req_bank;
  logic [ROW_BITS-1:0]  req_row;
  logic [COL_BITS-1:0]  req_col;
  logic                 row_hit;
  logic                 issue_prea;
  logic                 issue_pre;
  logic                 issue_act;
  logic                 issue_rw;

  assign req_bank = req_q.addr[ADDR_BITS-1 -: BANK_BITS];
  assign req_row  = req_q.addr[COL_BITS +: ROW_BITS];
  assign req_col  = req_q.addr[COL_BITS-1:0];
  assign row_hit  = open_q[req_bank] && (row_q[req_bank] == req_row);

  assign issue_prea = (state_q == ST_POWERUP) && (cnt_q == '0);
  assign issue_pre  = (state_q == ST_OPEN) && open_q[req_bank] && !row_hit;
  assign issue_act  = ((state_q == ST_OPEN) && !open_q[req_bank])
                   || ((state_q == ST_PRE_WAIT) && (cnt_q == '0));
  assign issue_rw   = ((state_q == ST_OPEN) && row_hit)
                   || ((state_q == ST_ACT_WAIT) && (cnt_q == '0));

  // One request in flight, and never a read without room for its data
  assign req_pop_o    = (state_q == ST_IDLE) && !req_empty_i && !rd_full_i;
  assign configured_o = configured_q;
  assign rd_push_o    = dfi_rvld_i;
  assign rd_word_o    = dfi_rdata_i;
  assign dfi_wdata_o  = req_q.wdata;

  always_comb begin
    dfi_cmd_o     = '0;
    dfi_cmd_o.cke = cke_q;
    {dfi_cmd_o.cs_n, dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} = CMD_NOP;
    if (issue_prea) begin
      {dfi_cmd_o.cs_n, dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} = CMD_PRE;
      dfi_cmd_o.addr[PRE_ALL_BIT] = 1'b1;
    end else if (issue_pre) begin
      {dfi_cmd_o.cs_n, dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} = CMD_PRE;
      dfi_cmd_o.bank = req_bank;
    end else if (issue_act) begin
      {dfi_cmd_o.cs_n, dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} = CMD_ACT;
      dfi_cmd_o.bank = req_bank;
      dfi_cmd_o.addr = req_row;
    end else if (issue_rw) begin
      {dfi_cmd_o.cs_n, dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} =
          req_q.is_write ? CMD_WR : CMD_RD;
      dfi_cmd_o.bank = req_bank;
      dfi_cmd_o.addr = ROW_BITS'(req_col);  // Column is zero-extended
      dfi_cmd_o.wren = req_q.is_write;
    end
  end

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q      <= ST_RESET;
      cnt_q        <= '0;
      cke_q        <= 1'b0;
      configured_q <= 1'b0;
      open_q       <= '0;
    end else begin
      if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;
      case (state_q)
        ST_RESET: begin
          cke_q   <= 1'b1;
          cnt_q   <= CNT_W'(INIT_CYCLES);
          state_q <= ST_POWERUP;
        end
        ST_PREA_WAIT: if (cnt_q == '0) begin
          configured_q <= 1'b1;  // Sticky from here on
          state_q      <= ST_IDLE;
        end
        ST_IDLE: if (req_pop_o) state_q <= ST_OPEN;
        ST_READ: if (dfi_rvld_i) state_q <= ST_IDLE;  // Word goes to the read FIFO
        default: ;
      endcase
      if (issue_prea) begin
        open_q  <= '0;
        cnt_q   <= CNT_W'(T_RP - 1);
        state_q <= ST_PREA_WAIT;
      end
      if (issue_pre) begin
        open_q[req_bank] <= 1'b0;
        cnt_q            <= CNT_W'(T_RP - 1);
        state_q          <= ST_PRE_WAIT;
      end
      if (issue_act) begin
        open_q[req_bank] <= 1'b1;
        cnt_q            <= CNT_W'(T_RCD - 1);
        state_q          <= ST_ACT_WAIT;
      end
      if (issue_rw) begin
        if (req_q.is_write) begin
          state_q <= ST_IDLE;
        end else begin
          cnt_q   <= CNT_W'(CL - 1);
          state_q <= ST_READ;
        end
      end
    end
  end

  // Open-row table and the request being served
  always_ff @(posedge mclk) begin
    if (issue_act) row_q[req_bank] <= req_row;
    if (req_pop_o) req_q <= req_i;
  end

endmodule

`default_nettype wire

//--- source/ddr_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_mem_top #(
  parameter int FIFO_DEPTH  = 4,
  parameter int INIT_CYCLES = 100,
  parameter int T_RP        = 3,
  parameter int T_RCD       = 3,
  parameter int CL          = 6
) (
  input  wire logic                              mclk,
  input  wire logic                              arst_n,
  input  wire logic                              s_tvalid_i,
  output logic                                   s_tready_o,
  input  wire logic [7:0]                        s_tdata_i,
  input  wire logic                              s_tlast_i,
  output logic                                   m_tvalid_o,
  input  wire logic                              m_tready_i,
  output logic [7:0]                             m_tdata_o,
  output logic                                   m_tlast_o,
  output logic                                   configured_o,
  output mem_cmd_pkg::dfi_cmd_t                  dfi_cmd_o,
  output logic [mem_cfg_pkg::DATA_BITS-1:0]      dfi_wdata_o,
  input  wire logic                              dfi_rvld_i,
  input  wire logic [mem_cfg_pkg::DATA_BITS-1:0] dfi_rdata_i
);

  import mem_cfg_pkg::*;
  import mem_cmd_pkg::*;

  mem_req_t             req_in, req_head;
  logic                 req_push, req_pop, req_full, req_empty;
  logic [DATA_BITS-1:0] rd_in, rd_head;
  logic                 rd_push, rd_pop, rd_full, rd_empty;

  stream_req_parser u_parser (
    .mclk         (mclk),
    .arst_n       (arst_n),
    .configured_i (configured_o),
    .s_tvalid_i   (s_tvalid_i),
    .s_tready_o   (s_tready_o),
    .s_tdata_i    (s_tdata_i),
    .s_tlast_i    (s_tlast_i),
    .m_tvalid_o   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .m_tdata_o    (m_tdata_o),
    .m_tlast_o    (m_tlast_o),
    .req_push_o   (req_push),
    .req_o        (req_in),
    .req_full_i   (req_full),
    .rd_pop_o     (rd_pop),
    .rd_word_i    (rd_head),
    .rd_empty_i   (rd_empty)
  );

  req_fifo #(.payload_t(mem_req_t), .DEPTH(FIFO_DEPTH)) u_req_q (
    .mclk    (mclk),
    .arst_n  (arst_n),
    .push_i  (req_push),
    .data_i  (req_in),
    .pop_i   (req_pop),
    .data_o  (req_head),
    .full_o  (req_full),
    .empty_o (req_empty)
  );

  // Read words back towards the host
  req_fifo #(.payload_t(logic [DATA_BITS-1:0]), .DEPTH(FIFO_DEPTH)) u_rd_q (
    .mclk    (mclk),
    .arst_n  (arst_n),
    .push_i  (rd_push),
    .data_i  (rd_in),
    .pop_i   (rd_pop),
    .data_o  (rd_head),
    .full_o  (rd_full),
    .empty_o (rd_empty)
  );

  ddr_cmd_sequencer #(
    .INIT_CYCLES (INIT_CYCLES),
    .T_RP        (T_RP),
    .T_RCD       (T_RCD),
    .CL          (CL)
  ) u_seq (
    .mclk         (mclk),
    .arst_n       (arst_n),
    .configured_o (configured_o),
    .req_i        (req_head),
    .req_empty_i  (req_empty),
    .req_pop_o    (req_pop),
    .rd_full_i    (rd_full),
    .rd_push_o    (rd_push),
    .rd_word_o    (rd_in),
    .dfi_cmd_o    (dfi_cmd_o),
    .dfi_wdata_o  (dfi_wdata_o),
    .dfi_rvld_i   (dfi_rvld_i),
    .dfi_rdata_i  (dfi_rdata_i)
  );

endmodule

`default_nettype wire

//--- source/mem_cfg_pkg.sv
`default_nettype none

package mem_cfg_pkg;

  // Word address layout is {bank, row, col}
  localparam int BANK_BITS = 3;
  localparam int ROW_BITS  = 13;
  localparam int COL_BITS  = 8;
  localparam int ADDR_BITS = BANK_BITS + ROW_BITS + COL_BITS;  // 24

  localparam int DATA_BITS = 32;  // One beat per access

  // Host command opcodes sent as the first byte of each header
  localparam logic [7:0] OP_WRITE = 8'h01;
  localparam logic [7:0] OP_READ  = 8'h02;

endpackage

`default_nettype wire

//--- source/mem_cmd_pkg.sv
`default_nettype none

package mem_cmd_pkg;

  // Request as queued between parser and sequencer
  typedef struct packed {
    logic                               is_write;
    logic [mem_cfg_pkg::ADDR_BITS-1:0]  addr;
    logic [mem_cfg_pkg::DATA_BITS-1:0]  wdata;
  } mem_req_t;

  // One DFI command slot per mclk cycle
  typedef struct packed {
    logic                               cke;
    logic                               cs_n;
    logic                               ras_n;
    logic                               cas_n;
    logic                               we_n;
    logic [mem_cfg_pkg::BANK_BITS-1:0]  bank;
    logic [mem_cfg_pkg::ROW_BITS-1:0]   addr;   // Row, column or A10 for PRE-all
    logic                               wren;   // Write data valid this cycle
  } dfi_cmd_t;

  // {cs_n, ras_n, cas_n, we_n} encodings
  localparam logic [3:0] CMD_NOP = 4'b0111;
  localparam logic [3:0] CMD_ACT = 4'b0011;
  localparam logic [3:0] CMD_RD  = 4'b0101;
  localparam logic [3:0] CMD_WR  = 4'b0100;
  localparam logic [3:0] CMD_PRE = 4'b0010;

  localparam int PRE_ALL_BIT = 10;  // A10 selects all banks

endpackage

`default_nettype wire

//--- source/req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  wire logic     mclk,
  input  wire logic     arst_n,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  input  wire logic     pop_i,
  output payload_t      data_o,
  output logic          full_o,
  output logic          empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t          mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              do_push;
  logic              do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];  // Head entry is valid while not empty

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge mclk) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

//--- source/stream_req_parser.sv
`timescale 1ns/1ps
`default_nettype none

module stream_req_parser (
  input  wire logic                              mclk,
  input  wire logic                              arst_n,
  input  wire logic                              configured_i,
  input  wire logic                              s_tvalid_i,
  output logic                                   s_tready_o,
  input  wire logic [7:0]                        s_tdata_i,
  input  wire logic                              s_tlast_i,
  output logic                                   m_tvalid_o,
  input  wire logic                              m_tready_i,
  output logic [7:0]                             m_tdata_o,
  output logic                                   m_tlast_o,
  output logic                                   req_push_o,
  output mem_cmd_pkg::mem_req_t                  req_o,
  input  wire logic                              req_full_i,
  output logic                                   rd_pop_o,
  input  wire logic [mem_cfg_pkg::DATA_BITS-1:0] rd_word_i,
  input  wire logic                              rd_empty_i
);

  import mem_cfg_pkg::*;
  import mem_cmd_pkg::*;

  typedef enum logic [1:0] {IN_OP, IN_ADDR, IN_DATA, IN_PUSH} in_state_e;

  in_state_e            in_state_q;
  logic [1:0]           in_cnt_q;
  logic                 known_q;     // Opcode recognised
  mem_req_t             req_q;
  logic                 in_fire;

  logic                 out_busy_q;
  logic [1:0]           out_cnt_q;
  logic [DATA_BITS-1:0] out_sr_q;
  logic                 out_fire;

  // Framing comes from byte counts alone
  assign s_tready_o = configured_i && !req_full_i && (in_state_q != IN_PUSH);
  assign in_fire    = s_tvalid_i && s_tready_o;
  assign req_push_o = (in_state_q == IN_PUSH) && !req_full_i;
  assign req_o      = req_q;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      in_state_q <= IN_OP;
      in_cnt_q   <= '0;
      known_q    <= 1'b0;
    end else begin
      case (in_state_q)
        IN_OP: if (in_fire) begin
          known_q    <= (s_tdata_i == OP_WRITE) || (s_tdata_i == OP_READ);
          in_cnt_q   <= '0;
          in_state_q <= IN_ADDR;
        end
        IN_ADDR: if (in_fire) begin
          in_cnt_q <= in_cnt_q + 1'b1;
          if (in_cnt_q == 2'd2) begin
            in_cnt_q <= '0;
            if (!known_q) in_state_q <= IN_OP;  // Drop the whole header
            else if (req_q.is_write) in_state_q <= IN_DATA;
            else in_state_q <= IN_PUSH;
          end
        end
        IN_DATA: if (in_fire) begin
          in_cnt_q <= in_cnt_q + 1'b1;
          if (in_cnt_q == 2'd3) in_state_q <= IN_PUSH;
        end
        IN_PUSH: if (req_push_o) in_state_q <= IN_OP;
        default: in_state_q <= IN_OP;
      endcase
    end
  end

  // Request fields shift in MSB first
  always_ff @(posedge mclk) begin
    if (in_fire) begin
      case (in_state_q)
        IN_OP:   req_q.is_write <= (s_tdata_i == OP_WRITE);
        IN_ADDR: req_q.addr     <= {req_q.addr[ADDR_BITS-9:0], s_tdata_i};
        IN_DATA: req_q.wdata    <= {req_q.wdata[DATA_BITS-9:0], s_tdata_i};
        default: ;
      endcase
    end
  end

  // Response side
  assign rd_pop_o   = !out_busy_q && !rd_empty_i;
  assign m_tvalid_o = out_busy_q;
  assign m_tdata_o  = out_sr_q[DATA_BITS-1 -: 8];
  assign m_tlast_o  = (out_cnt_q == 2'd3);
  assign out_fire   = out_busy_q && m_tready_i;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      out_busy_q <= 1'b0;
      out_cnt_q  <= '0;
    end else if (rd_pop_o) begin
      out_busy_q <= 1'b1;
      out_cnt_q  <= '0;
    end else if (out_fire) begin
      out_cnt_q <= out_cnt_q + 1'b1;
      if (out_cnt_q == 2'd3) out_busy_q <= 1'b0;  // Word done
    end
  end

  always_ff @(posedge mclk) begin
    if (rd_pop_o) out_sr_q <= rd_word_i;
    else if (out_fire) out_sr_q <= {out_sr_q[DATA_BITS-9:0], 8'h00};
  end

endmodule

`default_nettype wire

//--- test/dfi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dfi_mem_model #(
  parameter int T_RP  = 3,
  parameter int T_RCD = 3,
  parameter int CL    = 6
) (
  input  wire logic                              mclk,
  input  wire mem_cmd_pkg::dfi_cmd_t             dfi_cmd_i,
  input  wire logic [mem_cfg_pkg::DATA_BITS-1:0] dfi_wdata_i,
  output logic                                   dfi_rvld_o,
  output logic [mem_cfg_pkg::DATA_BITS-1:0]      dfi_rdata_o,
  output int                                     err_count_o
);

  import mem_cfg_pkg::*;
  import mem_cmd_pkg::*;

  localparam int BANKS = 1 << BANK_BITS;

  logic [DATA_BITS-1:0] mem [logic [ADDR_BITS-1:0]];  // Unwritten words read as zero
  logic                 open_q [BANKS] = '{default: 1'b0};
  logic [ROW_BITS-1:0]  row_q [BANKS]  = '{default: '0};
  int                   pre_cyc [BANKS] = '{default: -1000};
  int                   act_cyc [BANKS] = '{default: -1000};
  int                   due_q [$];    // Cycle in which each read word goes out
  logic [DATA_BITS-1:0] data_q [$];
  int                   cyc     = 0;
  int                   errors  = 0;
  logic                 rvld_q  = 1'b0;
  logic [DATA_BITS-1:0] rdata_q = '0;

  assign dfi_rvld_o  = rvld_q;
  assign dfi_rdata_o = rdata_q;
  assign err_count_o = errors;

  task automatic flag_error(input string msg);
    errors++;
    $display("ERROR: DFI model, cycle %0d: %s", cyc, msg);
  endtask

  // Commands are decoded just after the edge, where they are settled
  always @(posedge mclk) begin
    logic [3:0]           cmd;
    logic [BANK_BITS-1:0] b;
    logic [ADDR_BITS-1:0] a;
    #1;
    cyc++;
    cmd = {dfi_cmd_i.cs_n, dfi_cmd_i.ras_n, dfi_cmd_i.cas_n, dfi_cmd_i.we_n};
    b   = dfi_cmd_i.bank;
    a   = {b, row_q[b], dfi_cmd_i.addr[COL_BITS-1:0]};
    if (dfi_cmd_i.cke) begin
      if (dfi_cmd_i.wren != (cmd == CMD_WR)) flag_error("wren does not match a WRITE");
      case (cmd)
        CMD_PRE: begin
          for (int i = 0; i < BANKS; i++) begin
            if (dfi_cmd_i.addr[PRE_ALL_BIT] || i == int'(b)) begin
              open_q[i]  = 1'b0;
              pre_cyc[i] = cyc;
            end
          end
        end
        CMD_ACT: begin
          if (open_q[b]) flag_error("ACTIVATE to a bank that is already open");
          if (cyc - pre_cyc[b] < T_RP) flag_error("ACTIVATE issued before tRP elapsed");
          open_q[b]  = 1'b1;
          row_q[b]   = dfi_cmd_i.addr;
          act_cyc[b] = cyc;
        end
        CMD_RD, CMD_WR: begin
          if (!open_q[b]) flag_error("READ or WRITE to a closed bank");
          if (cyc - act_cyc[b] < T_RCD) flag_error("READ or WRITE issued before tRCD elapsed");
          if (dfi_cmd_i.addr[ROW_BITS-1:COL_BITS] != '0) flag_error("column not zero-extended");
          if (cmd == CMD_WR) begin
            mem[a] = dfi_wdata_i;
          end else begin
            due_q.push_back(cyc + CL);
            data_q.push_back(mem.exists(a) ? mem[a] : '0);
          end
        end
        default: ;
      endcase
    end
    rvld_q = 1'b0;
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      void'(due_q.pop_front());
      rvld_q  = 1'b1;
      rdata_q = data_q.pop_front();
    end
  end

endmodule

`default_nettype wire

//--- test/mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
  input  wire logic                              mclk,
  input  wire logic                              configured_i,
  input  wire logic                              s_tready_i,
  input  wire mem_cmd_pkg::dfi_cmd_t             dfi_cmd_i,
  input  wire logic                              m_tvalid_i,
  input  wire logic                              m_tready_i,
  input  wire logic [7:0]                        m_tdata_i,
  input  wire logic                              m_tlast_i,
  input  wire logic                              note_vld_i,
  input  wire logic                              note_write_i,
  input  wire logic [mem_cfg_pkg::ADDR_BITS-1:0] note_addr_i,
  input  wire logic [mem_cfg_pkg::DATA_BITS-1:0] note_data_i,
  input  wire logic [2:0]                        note_test_i,
  output int                                     err_count_o,
  output int                                     resp_count_o,
  output int                                     outstanding_o
);

  import mem_cfg_pkg::*;
  import mem_cmd_pkg::*;

  logic [DATA_BITS-1:0] shadow [logic [ADDR_BITS-1:0]];
  logic [DATA_BITS-1:0] exp_word_q [$];
  logic [2:0]           exp_test_q [$];
  logic [DATA_BITS-1:0] word_acc  = '0;
  int                   byte_idx  = 0;
  int                   errors    = 0;
  int                   responses = 0;
  int                   pending   = 0;

  assign err_count_o   = errors;
  assign resp_count_o  = responses;
  assign outstanding_o = pending;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "startup";
      3'd2:    return "write_read";
      3'd3:    return "unwritten_read";
      3'd4:    return "random_mix";
      3'd5:    return "backpressure";
      3'd6:    return "unknown_opcode";
      default: return "response";
    endcase
  endfunction

  // Sampled on the falling edge where DUT outputs and stimulus are both settled
  always @(negedge mclk) begin
    logic [3:0]           cmd;
    logic [DATA_BITS-1:0] expected;
    logic [2:0]           test_id;
    cmd     = {dfi_cmd_i.cs_n, dfi_cmd_i.ras_n, dfi_cmd_i.cas_n, dfi_cmd_i.we_n};
    test_id = (exp_test_q.size() > 0) ? exp_test_q[0] : 3'd0;
    if (!configured_i) begin
      if (s_tready_i) begin
        errors++;
        $display("ERROR: s_tready_o high before configured_o");
      end
      if (dfi_cmd_i.cke && (cmd == CMD_ACT || cmd == CMD_RD || cmd == CMD_WR)) begin
        errors++;
        $display("ERROR: ACTIVATE, READ or WRITE issued before configured_o");
      end
    end
    if (note_vld_i) begin
      if (note_write_i) begin
        shadow[note_addr_i] = note_data_i;
      end else begin
        exp_word_q.push_back(shadow.exists(note_addr_i) ? shadow[note_addr_i] : '0);
        exp_test_q.push_back(note_test_i);
        pending++;
      end
    end
    if (m_tvalid_i && m_tready_i) begin
      word_acc = {word_acc[DATA_BITS-9:0], m_tdata_i};  // MSB arrives first
      if (m_tlast_i != (byte_idx == 3)) begin
        errors++;
        $display("CHECK FAILED %s: tlast on byte %0d expected %0d actual %0d",
                 test_name(test_id), byte_idx, (byte_idx == 3), m_tlast_i);
      end
      if (byte_idx == 3) begin
        byte_idx = 0;
        responses++;
        if (pending == 0) begin
          errors++;
          $display("ERROR: response word %08h arrived with no read outstanding", word_acc);
        end else begin
          expected = exp_word_q.pop_front();
          void'(exp_test_q.pop_front());
          pending--;
          if (word_acc != expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %08h actual %08h",
                     test_name(test_id), expected, word_acc);
          end
        end
      end else begin
        byte_idx++;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_ddr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_mem;

  import mem_cfg_pkg::*;
  import mem_cmd_pkg::*;

  localparam int FIFO_DEPTH    = 4;
  localparam int INIT_CYCLES   = 20;
  localparam int T_RP          = 3;
  localparam int T_RCD         = 3;
  localparam int CL            = 5;
  localparam int CFG_TIMEOUT   = 200;
  localparam int BYTE_TIMEOUT  = 500;
  localparam int DRAIN_TIMEOUT = 20000;

  localparam logic [2:0] TEST_WRITE_READ   = 3'd2;
  localparam logic [2:0] TEST_UNWRITTEN    = 3'd3;
  localparam logic [2:0] TEST_RANDOM_MIX   = 3'd4;
  localparam logic [2:0] TEST_BACKPRESSURE = 3'd5;
  localparam logic [2:0] TEST_UNKNOWN_OP   = 3'd6;

  logic                 mclk;
  logic                 arst_n;
  logic                 s_tvalid;
  logic                 s_tready;
  logic [7:0]           s_tdata;
  logic                 s_tlast;
  logic                 m_tvalid;
  logic                 m_tready = 1'b1;
  logic [7:0]           m_tdata;
  logic                 m_tlast;
  logic                 configured;
  dfi_cmd_t             dfi_cmd;
  logic [DATA_BITS-1:0] dfi_wdata;
  logic                 dfi_rvld;
  logic [DATA_BITS-1:0] dfi_rdata;

  // Request notes towards the checker's shadow memory
  logic                 note_vld;
  logic                 note_write;
  logic [ADDR_BITS-1:0] note_addr;
  logic [DATA_BITS-1:0] note_data;
  logic [2:0]           note_test;

  int                   model_errors;
  int                   check_errors;
  int                   responses;
  int                   outstanding;
  int                   ready_pct = 100;  // Chance of m_tready_i per cycle
  int                   reads_sent;
  logic                 timeout_hit;

  ddr_mem_top #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .INIT_CYCLES (INIT_CYCLES),
    .T_RP        (T_RP),
    .T_RCD       (T_RCD),
    .CL          (CL)
  ) ddr_mem_top_inst (
    .mclk         (mclk),
    .arst_n       (arst_n),
    .s_tvalid_i   (s_tvalid),
    .s_tready_o   (s_tready),
    .s_tdata_i    (s_tdata),
    .s_tlast_i    (s_tlast),
    .m_tvalid_o   (m_tvalid),
    .m_tready_i   (m_tready),
    .m_tdata_o    (m_tdata),
    .m_tlast_o    (m_tlast),
    .configured_o (configured),
    .dfi_cmd_o    (dfi_cmd),
    .dfi_wdata_o  (dfi_wdata),
    .dfi_rvld_i   (dfi_rvld),
    .dfi_rdata_i  (dfi_rdata)
  );

  dfi_mem_model #(.T_RP(T_RP), .T_RCD(T_RCD), .CL(CL)) mem_model (
    .mclk        (mclk),
    .dfi_cmd_i   (dfi_cmd),
    .dfi_wdata_i (dfi_wdata),
    .dfi_rvld_o  (dfi_rvld),
    .dfi_rdata_o (dfi_rdata),
    .err_count_o (model_errors)
  );

  mem_checker resp_checker (
    .mclk          (mclk),
    .configured_i  (configured),
    .s_tready_i    (s_tready),
    .dfi_cmd_i     (dfi_cmd),
    .m_tvalid_i    (m_tvalid),
    .m_tready_i    (m_tready),
    .m_tdata_i     (m_tdata),
    .m_tlast_i     (m_tlast),
    .note_vld_i    (note_vld),
    .note_write_i  (note_write),
    .note_addr_i   (note_addr),
    .note_data_i   (note_data),
    .note_test_i   (note_test),
    .err_count_o   (check_errors),
    .resp_count_o  (responses),
    .outstanding_o (outstanding)
  );

  initial begin
    mclk = 1'b0;
    forever #5 mclk = ~mclk;
  end

  always @(posedge mclk) begin
    #1;
    m_tready = ($urandom_range(99) < ready_pct);
  end

  task automatic finish_run();
    int other;
    other = timeout_hit ? 1 : 0;
    if (responses != reads_sent) begin
      other++;
      $display("ERROR: %0d responses received for %0d reads sent", responses, reads_sent);
    end
    $display("Errors: model %0d, checker %0d, other %0d; responses %0d of %0d",
             model_errors, check_errors, other, responses, reads_sent);
    if (model_errors + check_errors + other == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("ERROR: timed out waiting for %s", what);
    timeout_hit = 1'b1;
    finish_run();
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_byte(input logic [7:0] data, input logic last);
    int waited;
    waited   = 0;
    s_tvalid = 1'b1;
    s_tdata  = data;
    s_tlast  = last;
    @(negedge mclk);
    while (!s_tready) begin
      if (waited == BYTE_TIMEOUT) abort_on_timeout("s_tready_o");
      waited++;
      @(negedge mclk);
    end
    @(posedge mclk);
    #1;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  task automatic send_command(input logic [7:0] op, input logic [ADDR_BITS-1:0] addr,
                              input logic [DATA_BITS-1:0] data, input logic [2:0] test_id);
    note_vld   = (op == OP_WRITE) || (op == OP_READ);
    note_write = (op == OP_WRITE);
    note_addr  = addr;
    note_data  = data;
    note_test  = test_id;
    if (op == OP_READ) reads_sent++;
    @(posedge mclk);
    #1;
    note_vld = 1'b0;
    send_byte(op, 1'b0);
    send_byte(addr[23:16], 1'b0);
    send_byte(addr[15:8], 1'b0);
    send_byte(addr[7:0], op != OP_WRITE);
    if (op == OP_WRITE) begin
      for (int i = 3; i >= 0; i--) send_byte(data[8*i +: 8], i == 0);
    end
  endtask

  task automatic wait_configured();
    int waited;
    waited = 0;
    @(negedge mclk);
    while (!configured) begin
      if (waited == CFG_TIMEOUT) abort_on_timeout("configured_o");
      waited++;
      @(negedge mclk);
    end
    @(posedge mclk);
    #1;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    @(negedge mclk);
    while (outstanding != 0) begin
      if (waited == DRAIN_TIMEOUT) abort_on_timeout("read responses");
      waited++;
      @(negedge mclk);
    end
    @(posedge mclk);
    #1;
  endtask

  // Three banks, three rows and four columns give plenty of hits and misses
  function automatic logic [ADDR_BITS-1:0] random_addr();
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;
    logic [COL_BITS-1:0]  col;
    bank = BANK_BITS'($urandom_range(2));
    row  = ROW_BITS'($urandom_range(3, 1));
    col  = COL_BITS'($urandom_range(3));
    return {bank, row, col};
  endfunction

  initial begin
    logic [ADDR_BITS-1:0] addr;
    void'($urandom(32'h828d19f0));
    arst_n      = 1'b1;
    s_tvalid    = 1'b0;
    s_tdata     = '0;
    s_tlast     = 1'b0;
    note_vld    = 1'b0;
    note_write  = 1'b0;
    note_addr   = '0;
    note_data   = '0;
    note_test   = '0;
    reads_sent  = 0;
    timeout_hit = 1'b0;
    #1 arst_n = 1'b0;
    repeat (4) @(posedge mclk);
    #1 arst_n = 1'b1;

    wait_configured();  // Checker watches the startup rules meanwhile

    addr = {3'd0, 13'd1, 8'd2};
    send_command(OP_WRITE, addr, 32'hdeadbeef, TEST_WRITE_READ);
    send_command(OP_READ, addr, '0, TEST_WRITE_READ);
    wait_responses();

    // Bank 5 is never written
    send_command(OP_READ, {3'd5, 13'd7, 8'd9}, '0, TEST_UNWRITTEN);
    wait_responses();

    ready_pct = 70;
    repeat (80) begin
      addr = random_addr();
      if ($urandom_range(1) == 1) send_command(OP_WRITE, addr, $urandom, TEST_RANDOM_MIX);
      else send_command(OP_READ, addr, '0, TEST_RANDOM_MIX);
    end
    wait_responses();

    // Long read burst against a slow consumer
    ready_pct = 25;
    repeat (24) send_command(OP_READ, random_addr(), '0, TEST_BACKPRESSURE);
    wait_responses();

    ready_pct = 100;
    send_command(8'h7e, 24'h010203, '0, TEST_UNKNOWN_OP);
    send_command(8'($urandom_range(255, 3)), random_addr(), '0, TEST_UNKNOWN_OP);
    addr = {3'd1, 13'd2, 8'd3};
    send_command(OP_WRITE, addr, 32'h0badf00d, TEST_UNKNOWN_OP);
    send_command(OP_READ, addr, '0, TEST_UNKNOWN_OP);
    send_command(OP_READ, {3'd0, 13'd1, 8'd2}, '0, TEST_UNKNOWN_OP);
    wait_responses();

    finish_run();
  end

endmodule

`default_nettype wire

//--- vlog.f
source/mem_cfg_pkg.sv
source/mem_cmd_pkg.sv
source/req_fifo.sv
source/stream_req_parser.sv
source/ddr_cmd_sequencer.sv
source/ddr_mem_top.sv
test/dfi_mem_model.sv
test/mem_checker.sv
test/tb_ddr_mem.sv
